// ==== project.f ====
mem_pkg.sv
pipe_reg.sv
rep_addr_gen.sv
dmem_port.sv
op_select.sv
mem_stage.sv
tb_dmem_model.sv
mem_stage_chk.sv
tb_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory stage testbench with Verilator
verilator --binary --timing --assert -f project.f --top-module tb_mem_stage -o sim_mem_stage \
    && ./obj_dir/sim_mem_stage | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage import mem_pkg::*; ();

    localparam int n_rows = 14;

    typedef struct {
        result_t res;
        int      row;
        logic    last;
    } expect_t;

    typedef struct {
        addr_t   addr;
        opsize_t size;
    } req_t;

    logic clk;
    logic rst_n;
    logic in_valid;
    opsize_t in_opsize;
    logic in_dir;
    logic in_is_rep;
    logic [rep_count_w-1:0] in_rep_count;
    addr_t in_addr;
    logic in_mem_rd;
    data_t in_reg_a;
    data_t in_reg_b;
    data_t in_imm;
    opsel_t in_op1_sel;
    opsel_t in_op2_sel;
    dstsel_t in_dst_sel;
    logic out_stall;
    logic dmem_ack;
    data_t dmem_rdata;
    logic stall;
    logic out_valid;
    data_t out_op1;
    data_t out_op2;
    addr_t out_dest_addr;
    logic dmem_req;
    addr_t dmem_addr;
    opsize_t dmem_size;

    uop_t    rows[n_rows];
    expect_t exp_q[$];
    req_t    req_q[$];
    int      errors;
    int      cycles;
    int      cycle_limit;
    logic    limit_ready;
    logic    stim_done;

    mem_stage DUT (.*);

    tb_dmem_model u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata)
    );

    bind mem_stage mem_stage_chk u_chk (.*);

    always #50 clk = ~clk;

    function automatic uop_t make_uop(input opsize_t sz, input logic dir, input logic rep,
                                      input logic [15:0] cnt, input addr_t addr,
                                      input logic rd, input data_t a, input data_t b,
                                      input data_t imm, input opsel_t s1, input opsel_t s2,
                                      input dstsel_t dst);
        uop_t u;
        u.opsize = sz;
        u.dir = dir;
        u.is_rep = rep;
        u.rep_count = cnt;
        u.addr = addr;
        u.mem_rd = rd;
        u.reg_a = a;
        u.reg_b = b;
        u.imm = imm;
        u.op1_sel = s1;
        u.op2_sel = s2;
        u.dst_sel = dst;
        return u;
    endfunction

    function automatic data_t width_mask(input opsize_t sz);
        case (sz)
            size_byte: return 32'h0000_00ff;
            size_word: return 32'h0000_ffff;
            default:   return 32'hffff_ffff;
        endcase
    endfunction

    // lane of the memory word at a, zero-extended to the operand size
    function automatic data_t expected_read(input addr_t a, input opsize_t sz);
        data_t w;
        w = {a[31:2], 2'b00} ^ 32'h5a5a_0000;
        w = w >> {a[1:0], 3'b000};
        return w & width_mask(sz);
    endfunction

    function automatic data_t pick(input uop_t u, input opsel_t s, input data_t memv);
        case (s)
            sel_reg_a: return u.reg_a;
            sel_reg_b: return u.reg_b;
            sel_mem:   return u.mem_rd ? memv : 32'h0;
            default:   return u.imm;
        endcase
    endfunction

    task automatic queue_expected(input uop_t u, input int row);
        int n;
        int step;
        addr_t a;
        data_t memv;
        expect_t e;
        req_t rq;
        n = u.is_rep ? int'(u.rep_count) : 1;
        step = (u.opsize == size_byte) ? 1 : (u.opsize == size_word) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            a = u.dir ? u.addr - addr_t'(i * step) : u.addr + addr_t'(i * step);
            memv = expected_read(a, u.opsize);
            e.res.op1 = pick(u, u.op1_sel, memv) & width_mask(u.opsize);
            e.res.op2 = pick(u, u.op2_sel, memv) & width_mask(u.opsize);
            e.res.dest_addr = (u.dst_sel == dst_mem) ? a : 32'h0;
            e.row = row;
            e.last = (i == n - 1);
            exp_q.push_back(e);
            if (u.mem_rd) begin
                rq.addr = a;
                rq.size = u.opsize;
                req_q.push_back(rq);
            end
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_size(input string name, input opsize_t got, input opsize_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_uop(input uop_t u);
        in_opsize = u.opsize;
        in_dir = u.dir;
        in_is_rep = u.is_rep;
        in_rep_count = u.rep_count;
        in_addr = u.addr;
        in_mem_rd = u.mem_rd;
        in_reg_a = u.reg_a;
        in_reg_b = u.reg_b;
        in_imm = u.imm;
        in_op1_sel = u.op1_sel;
        in_op2_sel = u.op2_sel;
        in_dst_sel = u.dst_sel;
    endtask

    // register-only op taken at the coming edge is on out_valid two edges later
    task automatic check_latency(input int row);
        logic free_run;
        @(posedge clk);
        @(negedge clk);
        @(negedge clk);
        #10;
        free_run = !out_stall;
        @(negedge clk);
        #10;
        if (free_run && !out_valid) begin
            $display("row %0d result not on out_valid two cycles after it was taken", row);
            errors++;
        end
    endtask

    task automatic build_table();
        // register-only ops
        rows[0] = make_uop(size_dword, 1'b0, 1'b0, 16'd0, 32'h0000_1000, 1'b0,
                           32'h1234_5678, 32'h9abc_def0, 32'hcafe_f00d, sel_reg_a, sel_imm, dst_reg);
        rows[1] = make_uop(size_byte, 1'b0, 1'b0, 16'd0, 32'h0000_1004, 1'b0,
                           32'h1111_2222, 32'h3333_44a5, 32'h5555_66c3, sel_reg_b, sel_imm, dst_reg);
        rows[2] = make_uop(size_word, 1'b0, 1'b0, 16'd0, 32'h0000_2002, 1'b0,
                           32'h7777_8899, 32'h0, 32'habcd_1357, sel_imm, sel_reg_a, dst_mem);
        // single reads at several lanes
        rows[3] = make_uop(size_byte, 1'b0, 1'b0, 16'd0, 32'h0000_3001, 1'b1,
                           32'h0102_0304, 32'h0, 32'h0, sel_mem, sel_reg_a, dst_mem);
        rows[4] = make_uop(size_byte, 1'b0, 1'b0, 16'd0, 32'h0000_3ab3, 1'b1,
                           32'h0, 32'hffff_ffff, 32'h0, sel_reg_b, sel_mem, dst_reg);
        rows[5] = make_uop(size_word, 1'b0, 1'b0, 16'd0, 32'h0004_0102, 1'b1,
                           32'h0, 32'h0, 32'h0000_beef, sel_mem, sel_imm, dst_mem);
        rows[6] = make_uop(size_dword, 1'b0, 1'b0, 16'd0, 32'h00c0_ffe8, 1'b1,
                           32'h2468_ace0, 32'h0, 32'h0, sel_mem, sel_reg_a, dst_mem);
        // repeated string reads, up and down
        rows[7] = make_uop(size_byte, 1'b0, 1'b1, 16'd5, 32'h0000_5002, 1'b1,
                           32'h0, 32'h0000_0042, 32'h0, sel_mem, sel_reg_b, dst_mem);
        rows[8] = make_uop(size_word, 1'b1, 1'b1, 16'd3, 32'h0000_6004, 1'b1,
                           32'h0000_1234, 32'h0, 32'h0, sel_reg_a, sel_mem, dst_mem);
        rows[9] = make_uop(size_dword, 1'b0, 1'b1, 16'd4, 32'h0001_7ff8, 1'b1,
                           32'h0, 32'h0, 32'h0f0f_0f0f, sel_mem, sel_imm, dst_mem);
        rows[10] = make_uop(size_dword, 1'b0, 1'b1, 16'd0, 32'h0000_8000, 1'b1,
                            32'hdead_0000, 32'h0, 32'h0, sel_mem, sel_reg_a, dst_mem);
        rows[11] = make_uop(size_dword, 1'b0, 1'b0, 16'd0, 32'h0000_9000, 1'b0,
                            32'h5555_aaaa, 32'h6666_bbbb, 32'h0, sel_reg_b, sel_reg_a, dst_reg);
        rows[12] = make_uop(size_dword, 1'b1, 1'b1, 16'd2, 32'h0000_a008, 1'b0,
                            32'h0000_0001, 32'h0, 32'h0000_0002, sel_reg_a, sel_imm, dst_mem);
        rows[13] = make_uop(size_word, 1'b0, 1'b0, 16'd0, 32'h0012_3450, 1'b1,
                            32'h0, 32'h8000_0001, 32'h0, sel_mem, sel_reg_b, dst_mem);
    endtask

    // result monitor, one check per result taken downstream
    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            #10;
            if (rst_n && out_valid && !out_stall) begin
                if (exp_q.size() == 0) begin
                    $display("result at %0t arrived with none expected", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_data("out_op1", out_op1, e.res.op1);
                    check_data("out_op2", out_op2, e.res.op2);
                    check_addr("out_dest_addr", out_dest_addr, e.res.dest_addr);
                    if (e.last) begin
                        $display("row %0d finished at %0t, errors so far %0d",
                                 e.row, $time, errors);
                    end
                end
            end
        end
    end

    // memory request monitor, address and size checked once per request
    initial begin
        req_t rq;
        logic req_seen;
        req_seen = 1'b0;
        forever begin
            @(negedge clk);
            #10;
            if (rst_n && dmem_req && !req_seen) begin
                if (req_q.size() == 0) begin
                    $display("memory request at %0t with none expected", $time);
                    errors++;
                end else begin
                    rq = req_q.pop_front();
                    check_addr("dmem_addr", dmem_addr, rq.addr);
                    check_size("dmem_size", dmem_size, rq.size);
                end
            end
            req_seen = dmem_req;
        end
    end

    // random back-pressure after reset
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && !stim_done) begin
                out_stall = ($urandom_range(0, 3) == 0);
            end else begin
                out_stall = 1'b0;
            end
        end
    end

    initial begin
        wait (limit_ready);
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int iters;
        void'($urandom(32'h4a7c8da0));
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        out_stall = 1'b0;
        stim_done = 1'b0;
        errors = 0;
        limit_ready = 1'b0;
        apply_uop('0);
        build_table();
        iters = 0;
        for (int r = 0; r < n_rows; r++) begin
            iters += rows[r].is_rep ? int'(rows[r].rep_count) : 1;
        end
        cycle_limit = iters * 40 + 200;
        limit_ready = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            apply_uop(rows[r]);
            in_valid = 1'b1;
            #10;
            while (stall) begin
                @(negedge clk);
                #10;
            end
            // taken at the coming rising edge
            queue_expected(rows[r], r);
            if (!rows[r].mem_rd && !rows[r].is_rep) begin
                fork
                    check_latency(r);
                join_none
            end
            if (rows[r].is_rep && rows[r].rep_count == 16'd0) begin
                $display("row %0d finished at %0t, zero count, no result", r, $time);
            end
            @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        stim_done = 1'b1;
        // catch any extra result
        repeat (10) @(negedge clk);

        errors += DUT.u_chk.fail_count;
        $display("rows %0d, iterations %0d, errors %0d", n_rows, iters, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_stage_chk.sv ====
`timescale 1ns/1ps

module mem_stage_chk import mem_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  dmem_req,
    input logic  dmem_ack,
    input logic  out_valid,
    input logic  out_stall,
    input data_t out_op1,
    input data_t out_op2,
    input addr_t out_dest_addr
);

    // number of assertion failures so far
    int fail_count = 0;

    // request held until the memory answers
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_ack |=> dmem_req)
        else begin
            fail_count++;
            $error("dmem_req dropped before dmem_ack");
        end

    // new request only once the previous ack is gone
    req_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dmem_req) |-> !dmem_ack)
        else begin
            fail_count++;
            $error("dmem_req raised while dmem_ack high");
        end

    out_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_stall |=> out_valid && $stable(out_op1) &&
            $stable(out_op2) && $stable(out_dest_addr))
        else begin
            fail_count++;
            $error("output changed under out_stall");
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !out_valid && !dmem_req)
        else begin
            fail_count++;
            $error("out_valid or dmem_req high after reset");
        end

endmodule

// ==== tb_dmem_model.sv ====
`timescale 1ns/1ps

module tb_dmem_model import mem_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  dmem_req,
    input  addr_t dmem_addr,
    output logic  dmem_ack,
    output data_t dmem_rdata
);

    int   wait_cnt;
    logic armed;

    // content rule: the dword at aligned address A holds A xor 5a5a_0000
    function automatic data_t word_at(input addr_t a);
        addr_t aligned;
        aligned = {a[31:2], 2'b00};
        return aligned ^ 32'h5a5a_0000;
    endfunction

    initial begin
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        wait_cnt   = 0;
        armed      = 1'b0;
    end

    // responder side of the four-phase cycle, moves on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            dmem_ack <= 1'b0;
            armed    <= 1'b0;
            wait_cnt <= 0;
        end else if (dmem_ack) begin
            if (!dmem_req) begin
                dmem_ack <= 1'b0;
            end
        end else if (dmem_req) begin
            if (!armed) begin
                // pick a random acknowledge delay for this request
                wait_cnt <= int'($urandom_range(0, 3));
                armed    <= 1'b1;
            end else if (wait_cnt == 0) begin
                dmem_ack   <= 1'b1;
                dmem_rdata <= word_at(dmem_addr);
                armed      <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  opsize_t                in_opsize,
    input  logic                   in_dir,
    input  logic                   in_is_rep,
    input  logic [rep_count_w-1:0] in_rep_count,
    input  addr_t                  in_addr,
    input  logic                   in_mem_rd,
    input  data_t                  in_reg_a,
    input  data_t                  in_reg_b,
    input  data_t                  in_imm,
    input  opsel_t                 in_op1_sel,
    input  opsel_t                 in_op2_sel,
    input  dstsel_t                in_dst_sel,
    input  logic                   out_stall,
    input  logic                   dmem_ack,
    input  data_t                  dmem_rdata,
    output logic                   stall,
    output logic                   out_valid,
    output data_t                  out_op1,
    output data_t                  out_op2,
    output addr_t                  out_dest_addr,
    output logic                   dmem_req,
    output addr_t                  dmem_addr,
    output opsize_t                dmem_size
);

    uop_t    in_uop;
    uop_t    held_uop;
    logic    hold_valid;
    logic    gen_start;
    logic    gen_busy;
    logic    iter_valid;
    logic    last_iter;
    addr_t   iter_addr;
    logic    mem_start;
    logic    mem_done;
    logic    mem_pend;
    logic    got_data;
    data_t   mem_data;
    logic    iter_done;
    logic    advance;
    logic    in_free;
    result_t res;
    result_t out_res;

    always_comb begin
        in_uop.opsize    = in_opsize;
        in_uop.dir       = in_dir;
        in_uop.is_rep    = in_is_rep;
        in_uop.rep_count = in_rep_count;
        in_uop.addr      = in_addr;
        in_uop.mem_rd    = in_mem_rd;
        in_uop.reg_a     = in_reg_a;
        in_uop.reg_b     = in_reg_b;
        in_uop.imm       = in_imm;
        in_uop.op1_sel   = in_op1_sel;
        in_uop.op2_sel   = in_op2_sel;
        in_uop.dst_sel   = in_dst_sel;
    end

    pipe_reg #(.payload_t(uop_t)) u_in (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (in_valid && !stall),
        .clear   (in_free),
        .d       (in_uop),
        .q       (held_uop),
        .q_valid (hold_valid)
    );

    // sequencer picks up a held op one cycle after it lands
    assign gen_start = hold_valid && !gen_busy;

    rep_addr_gen u_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (gen_start),
        .base_addr  (held_uop.addr),
        .opsize     (held_uop.opsize),
        .dir        (held_uop.dir),
        .is_rep     (held_uop.is_rep),
        .rep_count  (held_uop.rep_count),
        .advance    (advance),
        .iter_addr  (iter_addr),
        .iter_valid (iter_valid),
        .last_iter  (last_iter),
        .busy       (gen_busy)
    );

    // one read per iteration, data kept across back-pressure
    assign mem_start = iter_valid && held_uop.mem_rd && !mem_pend && !got_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_pend <= 1'b0;
            got_data <= 1'b0;
        end else begin
            if (mem_start) begin
                mem_pend <= 1'b1;
            end else if (mem_done) begin
                mem_pend <= 1'b0;
            end
            if (advance) begin
                got_data <= 1'b0;
            end else if (mem_done) begin
                got_data <= 1'b1;
            end
        end
    end

    dmem_port u_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (mem_start),
        .addr       (iter_addr),
        .size       (held_uop.opsize),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_size  (dmem_size),
        .done       (mem_done),
        .rdata      (mem_data)
    );

    op_select u_sel (
        .uop       (held_uop),
        .iter_addr (iter_addr),
        .mem_data  (mem_data),
        .result    (res)
    );

    assign iter_done = iter_valid && (!held_uop.mem_rd || mem_done || got_data);
    assign advance   = iter_done && !out_stall;

    // last result loaded, or a repeat with nothing to do
    assign in_free = (advance && last_iter) ||
                     (gen_start && held_uop.is_rep && (held_uop.rep_count == '0));
    assign stall   = hold_valid && !in_free;

    pipe_reg #(.payload_t(result_t)) u_out (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (advance),
        .clear   (!out_stall),
        .d       (res),
        .q       (out_res),
        .q_valid (out_valid)
    );

    assign out_op1       = out_res.op1;
    assign out_op2       = out_res.op2;
    assign out_dest_addr = out_res.dest_addr;

endmodule

// ==== op_select.sv ====
`timescale 1ns/1ps

module op_select import mem_pkg::*; (
    input  uop_t    uop,
    input  addr_t   iter_addr,
    input  data_t   mem_data,
    output result_t result
);

    data_t mem_val;
    data_t mask;
    data_t op1_raw;
    data_t op2_raw;

    function automatic data_t pick_src(
        input opsel_t sel,
        input data_t  reg_a,
        input data_t  reg_b,
        input data_t  mem,
        input data_t  imm
    );
        data_t val;
        case (sel)
            sel_reg_a: val = reg_a;
            sel_reg_b: val = reg_b;
            sel_mem:   val = mem;
            default:   val = imm;
        endcase
        return val;
    endfunction

    // memory operand only exists when the uop actually read memory
    assign mem_val = uop.mem_rd ? mem_data : '0;

    assign mask = size_mask[uop.opsize];

    always_comb begin
        op1_raw = pick_src(uop.op1_sel, uop.reg_a, uop.reg_b, mem_val, uop.imm);
        op2_raw = pick_src(uop.op2_sel, uop.reg_a, uop.reg_b, mem_val, uop.imm);
    end

    always_comb begin
        result.op1 = op1_raw & mask;
        result.op2 = op2_raw & mask;
        // register destinations carry no address
        if (uop.dst_sel == dst_mem) begin
            result.dest_addr = iter_addr;
        end else begin
            result.dest_addr = '0;
        end
    end

endmodule

// ==== dmem_port.sv ====
`timescale 1ns/1ps

module dmem_port import mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  addr_t   addr,
    input  opsize_t size,
    input  logic    dmem_ack,
    input  data_t   dmem_rdata,
    output logic    dmem_req,
    output addr_t   dmem_addr,
    output opsize_t dmem_size,
    output logic    done,
    output data_t   rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_rel,
        st_done
    } state_t;

    state_t state;
    data_t  lane_data;

    // four-phase cycle, a new request only after ack has dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (dmem_ack) begin
                        state <= st_rel;
                    end
                end
                st_rel: begin
                    // wait for the memory to release ack
                    if (!dmem_ack) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address and size held stable for the whole request
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            dmem_addr <= addr;
            dmem_size <= size;
        end
    end

    // move the addressed lane down, then cut to the operand size
    always_comb begin
        lane_data = dmem_rdata >> {dmem_addr[1:0], 3'b000};
        lane_data = lane_data & size_mask[dmem_size];
    end

    always_ff @(posedge clk) begin
        if (state == st_req && dmem_ack) begin
            rdata <= lane_data;
        end
    end

    assign dmem_req = (state == st_req);
    assign done     = (state == st_done);

endmodule

// ==== rep_addr_gen.sv ====
`timescale 1ns/1ps

module rep_addr_gen import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  addr_t                  base_addr,
    input  opsize_t                opsize,
    input  logic                   dir,
    input  logic                   is_rep,
    input  logic [rep_count_w-1:0] rep_count,
    input  logic                   advance,
    output addr_t                  iter_addr,
    output logic                   iter_valid,
    output logic                   last_iter,
    output logic                   busy
);

    logic                   active;
    logic [rep_count_w-1:0] remain;
    addr_t                  cur_addr;
    addr_t                  step;

    // signed step, downward when the direction flag is set
    always_comb begin
        step = addr_t'(size_step[opsize]);
        if (dir) begin
            step = -step;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            remain <= '0;
        end else if (start && !active) begin
            if (!is_rep) begin
                // plain op runs exactly once
                active <= 1'b1;
                remain <= rep_count_w'(1);
            end else if (rep_count != '0) begin
                active <= 1'b1;
                remain <= rep_count;
            end
            // a zero repeat count never becomes active
        end else if (advance && active) begin
            if (last_iter) begin
                active <= 1'b0;
            end
            remain <= remain - rep_count_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (start && !active) begin
            cur_addr <= base_addr;
        end else if (advance && active) begin
            cur_addr <= cur_addr + step;
        end
    end

    assign iter_addr  = cur_addr;
    assign iter_valid = active;
    assign last_iter  = active && (remain == rep_count_w'(1));
    assign busy       = active;

endmodule

// ==== pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  logic     clear,
    input  payload_t d,
    output payload_t q,
    output logic     q_valid
);

    // valid bit of the stage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (load) begin
            q_valid <= 1'b1;
        end else if (clear) begin
            // consumed and nothing new behind it
            q_valid <= 1'b0;
        end
    end

    // payload only moves on load, it is held otherwise
    always_ff @(posedge clk) begin
        if (load) begin
            q <= d;
        end
    end

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

    // width of the repeat counter, as loaded from the count register
    localparam int rep_count_w = 16;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } opsize_t;

    // operand source for op1 and op2
    typedef enum logic [1:0] {
        sel_reg_a = 2'd0,
        sel_reg_b = 2'd1,
        sel_mem   = 2'd2,
        sel_imm   = 2'd3
    } opsel_t;

    typedef enum logic {
        dst_reg = 1'b0,
        dst_mem = 1'b1
    } dstsel_t;

    // byte step per operand size, code 3 is not a valid size
    localparam logic [3:0][2:0] size_step = {3'd0, 3'd4, 3'd2, 3'd1};

    // zero-extension mask per operand size
    localparam logic [3:0][31:0] size_mask = {
        32'h0000_0000, 32'hffff_ffff, 32'h0000_ffff, 32'h0000_00ff
    };

    typedef struct packed {
        opsize_t                opsize;
        logic                   dir;
        logic                   is_rep;
        logic [rep_count_w-1:0] rep_count;
        addr_t                  addr;
        logic                   mem_rd;
        data_t                  reg_a;
        data_t                  reg_b;
        data_t                  imm;
        opsel_t                 op1_sel;
        opsel_t                 op2_sel;
        dstsel_t                dst_sel;
    } uop_t;

    typedef struct packed {
        data_t op1;
        data_t op2;
        addr_t dest_addr;
    } result_t;

endpackage
